// File: issue_top.f
rtl/issue_cfg_pkg.sv
rtl/issue_types_pkg.sv
rtl/fu_issue_if.sv
rtl/psel_gen.sv
rtl/rs.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/issue_top.sv
bench/issue_tb.sv

// File: Makefile
TOP = issue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f issue_top.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f issue_top.f

clean:
	rm -rf obj_dir sim.log

// File: bench/issue_tb.sv
`timescale 1ns/10ps

module issue_tb;
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    localparam int SIZE = 8;
    localparam int N    = 2;
    localparam int ROBS = 1 << ROB_WIDTH;

    logic                                clock = 1'b0;
    logic                                reset;
    logic [N-1:0]                        dispatch_valid;
    logic [N-1:0]                        dispatch_fu;
    logic [N-1:0][3:0]                   dispatch_func;
    logic [N-1:0]                        dispatch_op1_ready;
    logic [N-1:0][XLEN-1:0]              dispatch_op1;
    logic [N-1:0]                        dispatch_op2_ready;
    logic [N-1:0][XLEN-1:0]              dispatch_op2;
    logic [N-1:0][PRN_WIDTH-1:0]         dispatch_prn;
    logic [N-1:0][ROB_WIDTH-1:0]         dispatch_robn;
    logic [CDB_LANES-1:0]                cdb_valid;
    logic [CDB_LANES-1:0][PRN_WIDTH-1:0] cdb_prn;
    logic [CDB_LANES-1:0][XLEN-1:0]      cdb_value;
    logic [CDB_LANES-1:0][ROB_WIDTH-1:0] cdb_robn;
    logic                                almost_full;

    // reference model, indexed by robn
    logic [XLEN-1:0] exp_value [ROBS];
    logic            exp_lane [ROBS];                   // 0 alu, 1 mult
    logic [7:0]      issued [ROBS] = '{default: '0};    // stimulus side
    logic [7:0]      done [ROBS] = '{default: '0};      // monitor side
    int              model_count = 0;                   // slots held during fill test
    int              accepted_total = 0;
    int              completed_total = 0;
    int              check_errors = 0;
    int              wait_errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    int              errors_at_start = 0;
    int              seed = 79527;
    int              next_id = 0;
    bit              idle_check = 1'b0;
    bit              fill_check = 1'b0;

    issue_top #(.SIZE(SIZE), .N(N)) UUT (.*);

    always #50 clock = ~clock;

    function automatic logic [XLEN-1:0] expected_result(input op_func_e func,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            MUL_LO:  return prod[XLEN-1:0];
            MUL_HU:  return prod[2*XLEN-1:XLEN];
            default: return '0;
        endcase
    endfunction

    // result tags always have the top bit set, so low tags are never broadcast
    function automatic logic [PRN_WIDTH-1:0] prn_of(input int id);
        return {1'b1, id[ROB_WIDTH-1:0]};
    endfunction

    function automatic bit all_done();
        for (int r = 0; r < ROBS; r++)
            if (issued[r] != done[r])
                return 1'b0;
        return 1'b1;
    endfunction

    // result monitor, sees pre-edge values
    always @(posedge clock) begin
        if (!reset) begin
            for (int c = 0; c < CDB_LANES; c++) begin
                if (cdb_valid[c]) begin
                    done[cdb_robn[c]] = done[cdb_robn[c]] + 1'b1;
                    completed_total++;
                end
            end
        end
        if (!fill_check)
            model_count = 0;
        else if (model_count <= SIZE - N)
            model_count += $countones(dispatch_valid);  // whole dispatch taken or dropped
    end

    // outputs only move on rising edges, so check mid-cycle
    always @(negedge clock) begin
        logic [ROB_WIDTH-1:0] id;
        if (!reset) begin
            for (int c = 0; c < CDB_LANES; c++) begin
                if (cdb_valid[c]) begin
                    id = cdb_robn[c];
                    assert (issued[id] != done[id] && exp_lane[id] == (c == 1)) else begin
                        $display("lane %0d gave a result for robn %h that was not outstanding",
                                 c, id);
                        check_errors++;
                    end
                    assert (cdb_value[c] == exp_value[id]) else begin
                        $display("FAIL cdb_value[%0d] robn %h: got %h, expected %h",
                                 c, id, cdb_value[c], exp_value[id]);
                        check_errors++;
                    end
                    assert (cdb_prn[c] == prn_of(int'(id))) else begin
                        $display("FAIL cdb_prn[%0d] robn %h: got %h, expected %h",
                                 c, id, cdb_prn[c], prn_of(int'(id)));
                        check_errors++;
                    end
                end
            end
            assert (!idle_check || (cdb_valid == '0 && !almost_full)) else begin
                $display("activity on the outputs while the station should be idle");
                check_errors++;
            end
            assert (!fill_check || almost_full == (model_count > SIZE - N)) else begin
                $display("FAIL almost_full: got %h, expected %h",
                         almost_full, model_count > SIZE - N);
                check_errors++;
            end
        end
    end

    task automatic put_lane(input int lane, input op_func_e func, input logic r1,
                            input logic [XLEN-1:0] a, input logic r2, input logic [XLEN-1:0] b,
                            input logic [XLEN-1:0] value, output int id);
        logic is_mult;
        is_mult = (func == MUL_LO) || (func == MUL_HU);
        id      = next_id;
        next_id = (next_id + 1) % ROBS;
        dispatch_valid[lane]     = 1'b1;
        dispatch_fu[lane]        = is_mult;
        dispatch_func[lane]      = func;
        dispatch_op1_ready[lane] = r1;
        dispatch_op1[lane]       = a;
        dispatch_op2_ready[lane] = r2;
        dispatch_op2[lane]       = b;
        dispatch_prn[lane]       = prn_of(id);
        dispatch_robn[lane]      = id[ROB_WIDTH-1:0];
        if (!fill_check || model_count <= SIZE - N) begin
            exp_value[id] = value;
            exp_lane[id]  = is_mult;
            issued[id]    = issued[id] + 1'b1;
            if (!fill_check)
                accepted_total++;
        end
    endtask

    task automatic put_ready(input int lane, input op_func_e func, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, output int id);
        put_lane(lane, func, 1'b1, a, 1'b1, b, expected_result(func, a, b), id);
    endtask

    task automatic push();
        @(negedge clock);
        dispatch_valid = '0;
    endtask

    task automatic wait_room();
        int n;
        n = 0;
        while (almost_full) begin
            if (n == 50) begin
                $display("timeout: almost_full stayed high");
                wait_errors++;
                return;
            end
            @(negedge clock);
            n++;
        end
    endtask

    task automatic wait_all(input int limit);
        int n;
        n = 0;
        while (!all_done()) begin
            if (n == limit) begin
                $display("timeout: results still outstanding after %0d cycles", limit);
                wait_errors++;
                return;
            end
            @(negedge clock);
            n++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = check_errors + wait_errors - errors_at_start;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "errors");
        errors_at_start = check_errors + wait_errors;
    endtask

    initial begin
        int id0;
        int id1;
        logic [XLEN-1:0] a;
        bit drop;
        reset              = 1'b1;
        dispatch_valid     = '0;
        dispatch_fu        = '0;
        dispatch_func      = '0;
        dispatch_op1_ready = '0;
        dispatch_op1       = '0;
        dispatch_op2_ready = '0;
        dispatch_op2       = '0;
        dispatch_prn       = '0;
        dispatch_robn      = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        idle_check = 1'b1;
        repeat (20) @(negedge clock);
        idle_check = 1'b0;
        end_test("idle after reset");

        for (int r = 0; r < 2; r++) begin
            for (int f = 0; f < 8; f += 2) begin
                wait_room();
                put_ready(0, op_func_e'(f), $random(seed), $random(seed), id0);
                put_ready(1, op_func_e'(f + 1), $random(seed), $random(seed), id1);
                push();
            end
        end
        wait_all(100);
        end_test("alu functions");

        // alu to alu, op1 waits
        wait_room();
        put_ready(0, ALU_ADD, $random(seed), $random(seed), id0);
        a = $random(seed);
        put_lane(1, ALU_XOR, 1'b0, XLEN'(prn_of(id0)), 1'b1, a,
                 expected_result(ALU_XOR, exp_value[id0], a), id1);
        push();
        // mult to alu, op2 waits
        wait_room();
        put_ready(0, MUL_LO, $random(seed), $random(seed), id0);
        a = $random(seed);
        put_lane(1, ALU_SUB, 1'b1, a, 1'b0, XLEN'(prn_of(id0)),
                 expected_result(ALU_SUB, a, exp_value[id0]), id1);
        push();
        // alu to mult
        wait_room();
        put_ready(0, ALU_OR, $random(seed), $random(seed), id0);
        a = $random(seed);
        put_lane(1, MUL_HU, 1'b0, XLEN'(prn_of(id0)), 1'b1, a,
                 expected_result(MUL_HU, exp_value[id0], a), id1);
        push();
        wait_all(200);
        end_test("dependency chains");

        for (int k = 0; k < 3; k++) begin
            wait_room();
            put_ready(0, MUL_LO, $random(seed), $random(seed), id0);
            put_ready(1, MUL_HU, $random(seed), $random(seed), id1);
            push();
        end
        wait_all(200);
        end_test("back-to-back multiplies");

        // odd count first so the threshold is crossed by one
        fill_check = 1'b1;
        for (int k = 0; k < 6; k++) begin
            drop = (model_count > SIZE - N);    // ready ops here would issue if taken
            put_lane(0, ALU_ADD, drop, XLEN'(k), 1'b1, $random(seed), '0, id0);
            if (k > 0)
                put_lane(1, ALU_AND, 1'b1, $random(seed), drop, XLEN'(k), '0, id1);
            push();
        end
        repeat (20) @(negedge clock);
        fill_check = 1'b0;
        reset      = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        for (int r = 0; r < ROBS; r++)
            issued[r] = done[r];    // stuck ops are gone after reset
        idle_check = 1'b1;
        repeat (5) @(negedge clock);
        idle_check = 1'b0;
        end_test("fill and almost_full");

        assert (accepted_total == completed_total) else begin
            $display("%0d ops were accepted but %0d results were seen",
                     accepted_total, completed_total);
            wait_errors++;
        end
        end_test("every accepted op completed once");

        $display("tests %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, check_errors + wait_errors);
        if (check_errors + wait_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/issue_top.sv
`timescale 1ns/10ps

module issue_top #(
    parameter int SIZE = 8,
    parameter int N    = 2
) (
    input  logic                                               clock,
    input  logic                                               reset,
    input  logic [N-1:0]                                       dispatch_valid,
    input  logic [N-1:0]                                       dispatch_fu,
    input  logic [N-1:0][3:0]                                  dispatch_func,
    input  logic [N-1:0]                                       dispatch_op1_ready,
    input  logic [N-1:0][issue_cfg_pkg::XLEN-1:0]              dispatch_op1,
    input  logic [N-1:0]                                       dispatch_op2_ready,
    input  logic [N-1:0][issue_cfg_pkg::XLEN-1:0]              dispatch_op2,
    input  logic [N-1:0][issue_cfg_pkg::PRN_WIDTH-1:0]         dispatch_prn,
    input  logic [N-1:0][issue_cfg_pkg::ROB_WIDTH-1:0]         dispatch_robn,
    output logic [issue_cfg_pkg::CDB_LANES-1:0]                cdb_valid,
    output logic [issue_cfg_pkg::CDB_LANES-1:0][issue_cfg_pkg::PRN_WIDTH-1:0] cdb_prn,
    output logic [issue_cfg_pkg::CDB_LANES-1:0][issue_cfg_pkg::XLEN-1:0]      cdb_value,
    output logic [issue_cfg_pkg::CDB_LANES-1:0][issue_cfg_pkg::ROB_WIDTH-1:0] cdb_robn,
    output logic                                               almost_full
);
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    rs_entry_t [N-1:0]         dispatch;
    cdb_lane_t [CDB_LANES-1:0] cdb;         // lane 0 alu, lane 1 mult
    logic                      mult_avail;

    fu_issue_if alu_if ();
    fu_issue_if mult_if ();

    for (genvar l = 0; l < N; l++) begin : g_dispatch
        assign dispatch[l] = '{
            valid:     dispatch_valid[l],
            fu:        fu_type_e'(dispatch_fu[l]),
            func:      op_func_e'(dispatch_func[l]),
            op1_ready: dispatch_op1_ready[l],
            op1:       dispatch_op1[l],
            op2_ready: dispatch_op2_ready[l],
            op2:       dispatch_op2[l],
            dest_prn:  dispatch_prn[l],
            robn:      dispatch_robn[l]
        };
    end

    for (genvar c = 0; c < CDB_LANES; c++) begin : g_cdb
        assign cdb_valid[c] = cdb[c].valid;
        assign cdb_prn[c]   = cdb[c].dest_prn;
        assign cdb_value[c] = cdb[c].value;
        assign cdb_robn[c]  = cdb[c].robn;
    end

    rs #(.SIZE(SIZE), .N(N)) u_rs (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .mult_avail  (mult_avail),
        .alu_port    (alu_if.source),
        .mult_port   (mult_if.source),
        .almost_full (almost_full)
    );

    alu_unit u_alu (
        .clock  (clock),
        .reset  (reset),
        .issue  (alu_if.sink),
        .result (cdb[0])
    );

    mult_unit u_mult (
        .clock  (clock),
        .reset  (reset),
        .issue  (mult_if.sink),
        .avail  (mult_avail),
        .result (cdb[1])
    );

endmodule

// File: rtl/mult_unit.sv
`timescale 1ns/10ps

module mult_unit (
    input  logic                       clock,
    input  logic                       reset,
    fu_issue_if.sink                   issue,
    output logic                       avail,
    output issue_types_pkg::cdb_lane_t result
);
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} mult_state_e;

    localparam int STEPS  = XLEN / MULT_STEP;
    localparam int STEP_W = $clog2(STEPS);

    mult_state_e          state;
    logic [STEP_W-1:0]    step;
    logic                 accept;
    logic                 last;
    logic [2*XLEN-1:0]    acc;
    logic [2*XLEN-1:0]    mcand;        // shifts left each step
    logic [XLEN-1:0]      mplier;       // shifts right each step
    logic [2*XLEN-1:0]    digit;
    logic [2*XLEN-1:0]    sum;
    op_func_e             func_q;
    logic [PRN_WIDTH-1:0] prn_q;
    logic [ROB_WIDTH-1:0] robn_q;
    logic                 res_valid;
    logic [XLEN-1:0]      res_value;
    logic [PRN_WIDTH-1:0] res_prn;
    logic [ROB_WIDTH-1:0] res_robn;

    assign avail  = (state != RUN);
    assign accept = avail && issue.valid;
    assign last   = (state == RUN) && (step == STEP_W'(STEPS - 1));
    assign digit  = (2*XLEN)'(mplier[MULT_STEP-1:0]);
    assign sum    = acc + mcand * digit;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            step      <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= last;
            case (state)
                IDLE, DONE: begin
                    state <= accept ? RUN : IDLE;
                    step  <= '0;
                end
                RUN: begin
                    step <= step + 1'b1;
                    if (last)
                        state <= DONE;  // result shows in DONE
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= (2*XLEN)'(issue.op1);
            mplier <= issue.op2;
            func_q <= issue.func;
            prn_q  <= issue.dest_prn;
            robn_q <= issue.robn;
        end else if (state == RUN) begin
            acc    <= sum;
            mcand  <= mcand << MULT_STEP;
            mplier <= mplier >> MULT_STEP;
        end
        if (last) begin
            res_value <= (func_q == MUL_HU) ? sum[2*XLEN-1:XLEN] : sum[XLEN-1:0];
            res_prn   <= prn_q;
            res_robn  <= robn_q;
        end
    end

    assign result = '{valid: res_valid, dest_prn: res_prn, value: res_value, robn: res_robn};

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  logic                       clock,
    input  logic                       reset,
    fu_issue_if.sink                   issue,
    output issue_types_pkg::cdb_lane_t result
);
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    logic [XLEN-1:0]      value;
    logic                 res_valid;
    logic [XLEN-1:0]      res_value;
    logic [PRN_WIDTH-1:0] res_prn;
    logic [ROB_WIDTH-1:0] res_robn;

    always_comb begin
        case (issue.func)
            ALU_ADD: value = issue.op1 + issue.op2;
            ALU_SUB: value = issue.op1 - issue.op2;
            ALU_AND: value = issue.op1 & issue.op2;
            ALU_OR:  value = issue.op1 | issue.op2;
            ALU_XOR: value = issue.op1 ^ issue.op2;
            ALU_SLL: value = issue.op1 << issue.op2[4:0];
            ALU_SRL: value = issue.op1 >> issue.op2[4:0];    // logical
            ALU_SLT: value = {{(XLEN-1){1'b0}}, $signed(issue.op1) < $signed(issue.op2)};
            default: value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            res_valid <= 1'b0;
        else
            res_valid <= issue.valid;   // one cycle per packet
    end

    always_ff @(posedge clock) begin
        res_value <= value;
        res_prn   <= issue.dest_prn;
        res_robn  <= issue.robn;
    end

    assign result = '{valid: res_valid, dest_prn: res_prn, value: res_value, robn: res_robn};

endmodule

// File: rtl/rs.sv
`timescale 1ns/10ps

module rs #(
    parameter int SIZE = 8,
    parameter int N    = 2
) (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  issue_types_pkg::rs_entry_t [N-1:0]                   dispatch,
    input  issue_types_pkg::cdb_lane_t [issue_cfg_pkg::CDB_LANES-1:0] cdb,
    input  logic                                                 mult_avail,
    fu_issue_if.source                                           alu_port,
    fu_issue_if.source                                           mult_port,
    output logic                                                 almost_full
);
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    localparam int CNT_W = $clog2(SIZE + 1);

    rs_entry_t [SIZE-1:0] entries;
    rs_entry_t [SIZE-1:0] next_entries;
    logic [CNT_W-1:0]     count;            // occupied slots
    logic [CNT_W-1:0]     next_count;

    logic [SIZE-1:0] alu_req;
    logic [SIZE-1:0] mult_req;
    logic [SIZE-1:0] alu_gnt;
    logic [SIZE-1:0] mult_gnt;
    logic            mult_take;
    rs_entry_t       alu_pick;
    rs_entry_t       mult_pick;

    // per-type ready vectors from the registered slots
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            alu_req[i]  = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && (entries[i].fu == FU_ALU);
            mult_req[i] = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && (entries[i].fu == FU_MULT);
        end
    end

    // a packet still on its way has not lowered avail yet
    assign mult_take = mult_avail && !mult_port.valid;

    psel_gen #(.WIDTH(SIZE)) alu_selector (
        .clock (clock),
        .reset (reset),
        .req   (alu_req),
        .take  (1'b1),      // alu never stalls
        .gnt   (alu_gnt)
    );

    psel_gen #(.WIDTH(SIZE)) mult_selector (
        .clock (clock),
        .reset (reset),
        .req   (mult_req),
        .take  (mult_take),
        .gnt   (mult_gnt)
    );

    // one-hot mux of the winners
    always_comb begin
        alu_pick  = '0;
        mult_pick = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (alu_gnt[i])
                alu_pick = entries[i];
            if (mult_gnt[i])
                mult_pick = entries[i];
        end
    end

    assign almost_full = (count > CNT_W'(SIZE - N));

    always_comb begin
        logic [SIZE-1:0] taken;
        logic            placed;
        next_entries = entries;
        next_count   = count;

        // free what issues this cycle
        for (int i = 0; i < SIZE; i++) begin
            if (alu_gnt[i] || (mult_gnt[i] && mult_take)) begin
                next_entries[i].valid = 1'b0;
                next_count            = next_count - 1'b1;
            end
        end

        // fill lowest free slots in lane order
        for (int i = 0; i < SIZE; i++)
            taken[i] = entries[i].valid;
        for (int l = 0; l < N; l++) begin
            placed = 1'b0;
            if (dispatch[l].valid && !almost_full) begin
                for (int i = 0; i < SIZE; i++) begin
                    if (!placed && !taken[i]) begin
                        next_entries[i] = dispatch[l];
                        taken[i]        = 1'b1;
                        placed          = 1'b1;
                        next_count      = next_count + 1'b1;
                    end
                end
            end
        end

        // wakeup, new arrivals included
        for (int i = 0; i < SIZE; i++) begin
            for (int c = 0; c < CDB_LANES; c++) begin
                if (cdb[c].valid && next_entries[i].valid) begin
                    if (!next_entries[i].op1_ready
                        && next_entries[i].op1[PRN_WIDTH-1:0] == cdb[c].dest_prn) begin
                        next_entries[i].op1_ready = 1'b1;
                        next_entries[i].op1       = cdb[c].value;
                    end
                    if (!next_entries[i].op2_ready
                        && next_entries[i].op2[PRN_WIDTH-1:0] == cdb[c].dest_prn) begin
                        next_entries[i].op2_ready = 1'b1;
                        next_entries[i].op2       = cdb[c].value;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            for (int i = 0; i < SIZE; i++)
                entries[i].valid <= 1'b0;
        end else begin
            count   <= next_count;
            entries <= next_entries;
        end
    end

    // issue packets
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_port.valid  <= 1'b0;
            mult_port.valid <= 1'b0;
        end else begin
            alu_port.valid  <= |alu_gnt;
            mult_port.valid <= (|mult_gnt) && mult_take;
        end
    end

    always_ff @(posedge clock) begin
        alu_port.func      <= alu_pick.func;
        alu_port.op1       <= alu_pick.op1;
        alu_port.op2       <= alu_pick.op2;
        alu_port.dest_prn  <= alu_pick.dest_prn;
        alu_port.robn      <= alu_pick.robn;
        mult_port.func     <= mult_pick.func;
        mult_port.op1      <= mult_pick.op1;
        mult_port.op2      <= mult_pick.op2;
        mult_port.dest_prn <= mult_pick.dest_prn;
        mult_port.robn     <= mult_pick.robn;
    end

endmodule

// File: rtl/psel_gen.sv
`timescale 1ns/10ps

module psel_gen #(
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [WIDTH-1:0] req,
    input  logic             take,
    output logic [WIDTH-1:0] gnt
);
    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [PTR_W-1:0] ptr;          // first index to look at
    logic [PTR_W-1:0] gnt_idx;
    logic             found;

    // scan from ptr upward, wrapping around
    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = (int'(ptr) + k) % WIDTH;
            if (!found && req[idx]) begin
                gnt[idx] = 1'b1;
                gnt_idx  = PTR_W'(idx);
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (take && found) begin
            ptr <= (gnt_idx == PTR_W'(WIDTH - 1)) ? '0 : gnt_idx + 1'b1;  // step past winner
        end
    end

endmodule

// File: rtl/fu_issue_if.sv
`timescale 1ns/10ps

interface fu_issue_if;
    import issue_cfg_pkg::*;
    import issue_types_pkg::*;

    logic                 valid;        // one pulse per instruction
    op_func_e             func;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [PRN_WIDTH-1:0] dest_prn;
    logic [ROB_WIDTH-1:0] robn;

    // station side
    modport source (
        output valid, func, op1, op2, dest_prn, robn
    );

    // functional unit side
    modport sink (
        input valid, func, op1, op2, dest_prn, robn
    );

endinterface

// File: rtl/issue_types_pkg.sv
package issue_types_pkg;

    // target functional unit
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    // operation within the unit
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7,     // signed compare
        MUL_LO  = 4'h8,     // low word of product
        MUL_HU  = 4'h9      // high word, unsigned
    } op_func_e;

    // one reservation station slot, also the dispatch lane format
    typedef struct packed {
        logic                           valid;
        fu_type_e                       fu;
        op_func_e                       func;
        logic                           op1_ready;
        logic [issue_cfg_pkg::XLEN-1:0] op1;        // tag in low bits while waiting
        logic                           op2_ready;
        logic [issue_cfg_pkg::XLEN-1:0] op2;        // same for op2
        logic [issue_cfg_pkg::PRN_WIDTH-1:0] dest_prn;
        logic [issue_cfg_pkg::ROB_WIDTH-1:0] robn;
    } rs_entry_t;

    // one common data bus lane
    typedef struct packed {
        logic                                valid;
        logic [issue_cfg_pkg::PRN_WIDTH-1:0] dest_prn;
        logic [issue_cfg_pkg::XLEN-1:0]      value;
        logic [issue_cfg_pkg::ROB_WIDTH-1:0] robn;
    } cdb_lane_t;

endpackage

// File: rtl/issue_cfg_pkg.sv
package issue_cfg_pkg;

    // datapath
    localparam int XLEN      = 32;  // data word
    localparam int MULT_STEP = 4;   // multiplier bits per cycle

    // tags
    localparam int PRN_WIDTH = 6;   // physical register tag
    localparam int ROB_WIDTH = 5;   // reorder buffer index

    // result broadcast
    localparam int CDB_LANES = 2;   // lane 0 alu, lane 1 mult

endpackage
